// File: gba_irq_pkg.sv
// interrupt subsystem package
package gba_irq_pkg;

    // display timing, one frame is h_total x v_total clocks
    localparam int h_total = 308;
    localparam int v_total = 228;
    localparam logic [8:0] h_blank_start = 9'd240; // first dot of hblank
    localparam logic [7:0] v_blank_start = 8'd160; // first line of vblank

    localparam logic [4:0] cpsr_mode_irq = 5'b10010; // cpu IRQ mode
    localparam int num_irq = 14;

    // register map, byte addresses
    localparam logic [3:0] addr_ie_if = 4'h0;
    localparam logic [3:0] addr_ime = 4'h4;
    localparam logic [3:0] addr_dispstat = 4'h8; // compare in 15:8
    localparam logic [3:0] addr_vcount = 4'hc;   // read only

    localparam logic [1:0] axi_resp_okay = 2'b00;
    localparam logic [1:0] axi_resp_slverr = 2'b10;

    // bit 0 vblank, 1 hblank, 2 vcount, 3..6 timers, 7 serial,
    // 8..11 dma, 12 keypad, 13 game pak
    typedef logic [num_irq-1:0] irq_vec_t;

    // declared msb first so timer0 lands on bit 0
    typedef struct packed {
        logic game_pak;
        logic keypad;
        logic dma3;
        logic dma2;
        logic dma1;
        logic dma0;
        logic serial;
        logic timer3;
        logic timer2;
        logic timer1;
        logic timer0;
    } irq_sources_t;

    typedef struct packed {
        logic [8:0] hcount;
        logic [7:0] vcount;
    } video_pos_t;

    // IE_IF word: flags or ack bits above, enable below
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [15:0] if_ack;
            logic [15:0] ie;
        } split;
    } irq_word_u;

endpackage

// File: video_timing.sv
// video dot and line counters
module video_timing import gba_irq_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    output video_pos_t pos
);

    logic h_wrap; // last dot of the line
    logic v_wrap; // last line of the frame

    assign h_wrap = (pos.hcount == 9'(h_total - 1));
    assign v_wrap = (pos.vcount == 8'(v_total - 1));

    // dot counter, one dot per clock
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            pos.hcount <= '0;
        end else if (h_wrap) begin
            pos.hcount <= '0;
        end else begin
            pos.hcount <= pos.hcount + 9'd1;
        end
    end

    // line counter steps at end of line
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            pos.vcount <= '0;
        end else if (h_wrap) begin
            if (v_wrap) begin
                pos.vcount <= '0;
            end else begin
                pos.vcount <= pos.vcount + 8'd1;
            end
        end
    end

endmodule

// File: interrupt_controller.sv
// interrupt request controller
module interrupt_controller import gba_irq_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  video_pos_t   pos,
    input  logic [7:0]   set_vcount,
    input  irq_sources_t sources,
    input  logic [4:0]   cpu_mode,
    input  irq_vec_t     ie,
    input  logic         ime,
    input  irq_vec_t     ack,
    output irq_vec_t     flags,
    output logic         nIRQ
);

    logic vblank_cond, hblank_cond, vmatch_cond;
    logic vblank_prev, hblank_prev, vmatch_prev;
    logic vblank_ev, hblank_ev, vmatch_ev; // one cycle pulses
    irq_vec_t set_vec;
    irq_vec_t pending;                     // flags that pass ie
    logic irq_req;

    assign vblank_cond = (pos.vcount == v_blank_start);
    assign hblank_cond = (pos.hcount == h_blank_start);
    assign vmatch_cond = (pos.vcount == set_vcount);

    // previous condition values for edge detection
    // a condition already true out of reset is not an entry, so start at 1
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            vblank_prev <= 1'b1;
            hblank_prev <= 1'b1;
            vmatch_prev <= 1'b1;
        end else begin
            vblank_prev <= vblank_cond;
            hblank_prev <= hblank_cond;
            vmatch_prev <= vmatch_cond;
        end
    end

    assign vblank_ev = vblank_cond & ~vblank_prev;
    assign hblank_ev = hblank_cond & ~hblank_prev;
    assign vmatch_ev = vmatch_cond & ~vmatch_prev;

    // peripheral lines sit above the three display events
    assign set_vec = {sources, vmatch_ev, hblank_ev, vblank_ev};

    // sticky flags, ack has priority over a new set
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            flags <= '0;
        end else begin
            flags <= (flags | set_vec) & ~ack;
        end
    end

    assign pending = flags & ie;

    // no new request while the cpu is already servicing one
    assign irq_req = (|pending) & ime & (cpu_mode != cpsr_mode_irq);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            nIRQ <= 1'b1;
        end else begin
            nIRQ <= ~irq_req; // active low
        end
    end

endmodule

// File: irq_regs.sv
// interrupt register block, AXI4-Lite slave
module irq_regs import gba_irq_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    input  irq_vec_t    flags,
    input  video_pos_t  pos,
    output irq_vec_t    ie,
    output logic        ime,
    output logic [7:0]  set_vcount,
    output irq_vec_t    ack
);

    logic      live;    // set one cycle after reset
    logic      wr_hs, rd_hs;
    irq_word_u wr_word;
    irq_word_u rd_word;
    logic [1:0] wr_resp, rd_resp;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            live <= 1'b0;
        end else begin
            live <= 1'b1;
        end
    end

    // address and data taken together, one write in flight
    assign awready = live & awvalid & wvalid & ~bvalid;
    assign wready = awready;
    assign arready = live & ~rvalid;

    assign wr_hs = awvalid & wvalid & awready;
    assign rd_hs = arvalid & arready;

    assign wr_word.raw = wdata;

    always_comb begin
        case (awaddr)
            addr_ie_if, addr_ime, addr_dispstat: wr_resp = axi_resp_okay;
            default: wr_resp = axi_resp_slverr; // vcount is read only
        endcase
    end

    // register writes, ack lasts one cycle alongside bvalid
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            ie <= '0;
            ime <= 1'b0;
            set_vcount <= '0;
            ack <= '0;
            bvalid <= 1'b0;
        end else begin
            ack <= '0;
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (wr_hs) begin
                bvalid <= 1'b1;
                case (awaddr)
                    addr_ie_if: begin
                        ie <= wr_word.split.ie[num_irq-1:0];
                        ack <= wr_word.split.if_ack[num_irq-1:0]; // write 1 to clear
                    end
                    addr_ime: ime <= wdata[0];
                    addr_dispstat: set_vcount <= wdata[15:8];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        rd_word.raw = '0;
        rd_resp = axi_resp_okay;
        case (araddr)
            addr_ie_if: begin
                rd_word.split.if_ack = 16'(flags & ie); // only enabled flags show
                rd_word.split.ie = 16'(ie);
            end
            addr_ime: rd_word.raw = {31'b0, ime};
            addr_dispstat: rd_word.raw = {16'b0, set_vcount, 8'b0};
            addr_vcount: rd_word.raw = {24'b0, pos.vcount};
            default: rd_resp = axi_resp_slverr;
        endcase
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            rvalid <= 1'b0;
        end else if (rd_hs) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // response payloads
    always_ff @(posedge clock) begin
        if (wr_hs) begin
            bresp <= wr_resp;
        end
        if (rd_hs) begin
            rdata <= rd_word.raw;
            rresp <= rd_resp;
        end
    end

endmodule

// File: gba_irq_top.sv
// interrupt subsystem top level
module gba_irq_top import gba_irq_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic [3:0]   awaddr,
    input  logic         awvalid,
    output logic         awready,
    input  logic [31:0]  wdata,
    input  logic         wvalid,
    output logic         wready,
    output logic [1:0]   bresp,
    output logic         bvalid,
    input  logic         bready,
    input  logic [3:0]   araddr,
    input  logic         arvalid,
    output logic         arready,
    output logic [31:0]  rdata,
    output logic [1:0]   rresp,
    output logic         rvalid,
    input  logic         rready,
    input  irq_sources_t sources,
    input  logic [4:0]   cpu_mode,
    output logic         nIRQ
);

    video_pos_t pos;
    irq_vec_t   ie;
    irq_vec_t   ack;
    irq_vec_t   flags;  // raw, unmasked
    logic       ime;
    logic [7:0] set_vcount;

    video_timing u_timing (
        .clock (clock),
        .reset (reset),
        .pos   (pos)
    );

    interrupt_controller u_irq (
        .clock      (clock),
        .reset      (reset),
        .pos        (pos),
        .set_vcount (set_vcount),
        .sources    (sources),
        .cpu_mode   (cpu_mode),
        .ie         (ie),
        .ime        (ime),
        .ack        (ack),
        .flags      (flags),
        .nIRQ       (nIRQ)
    );

    irq_regs u_regs (
        .clock      (clock),
        .reset      (reset),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .flags      (flags),
        .pos        (pos),
        .ie         (ie),
        .ime        (ime),
        .set_vcount (set_vcount),
        .ack        (ack)
    );

endmodule

// File: tb_clock.sv
// testbench clock source
module tb_clock (
    output logic clock
);

    initial begin
        clock = 1'b0;
    end

    always #2 clock = ~clock; // period 4

endmodule

// File: gba_irq_chk.sv
// interrupt subsystem assertions
module gba_irq_chk import gba_irq_pkg::*; (
    input logic     clock,
    input logic     reset,
    input logic     ime,
    input logic     nIRQ,
    input logic     bvalid,
    input logic     bready,
    input logic     rvalid,
    input logic     rready,
    input irq_vec_t ie,
    input irq_vec_t flags
);

    logic [9:0] hb_wait; // cycles with hblank enabled and clear

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            hb_wait <= '0;
        end else if (ie[1] && !flags[1]) begin
            hb_wait <= hb_wait + 10'd1;
        end else begin
            hb_wait <= '0;
        end
    end

    a_ime_off: assert property (@(posedge clock) disable iff (reset) !ime |=> nIRQ)
        else $error("nIRQ low while ime clear");
    a_bvalid_hold: assert property (@(posedge clock) disable iff (reset)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");
    a_rvalid_hold: assert property (@(posedge clock) disable iff (reset)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");
    a_hblank_due: assert property (@(posedge clock) disable iff (reset)
        hb_wait <= 10'(h_total))
        else $error("hblank flag missing for a whole line");

endmodule

bind gba_irq_top gba_irq_chk chk (.*);

// File: gba_irq_tb.sv
// interrupt subsystem testbench
module gba_irq_tb import gba_irq_pkg::*; ();

    logic         clock;
    logic         reset;
    logic [3:0]   awaddr, araddr;
    logic         awvalid, wvalid, bready, arvalid, rready;
    logic         awready, wready, bvalid, arready, rvalid;
    logic [31:0]  wdata, rdata;
    logic [1:0]   bresp, rresp;
    irq_sources_t sources;
    logic [4:0]   cpu_mode;
    logic         nIRQ;

    logic [7:0]   op_q[$];        // operation letter per pattern line
    logic [31:0]  a_q[$], b_q[$], c_q[$];
    longint       watchdog_time;
    bit           loaded;

    tb_clock u_clock (.clock(clock));

    gba_irq_top dut (.*);

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input irq_word_u exp, input irq_word_u act);
        if (act.raw !== exp.raw)
            abort_run($sformatf("[FAIL] t=%0t %s expected %h got %h",
                $time, name, exp.raw, act.raw));
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp)
            abort_run($sformatf("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, act));
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, act));
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [31:0] resp);
        int delay;
        delay = 1 + int'($urandom % 3); // bready back-pressure
        @(posedge clock);
        awaddr <= addr[3:0];
        wdata <= data;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        @(negedge clock);
        while (!awready) @(negedge clock);
        check_level("wready", 1'b1, wready); // rises with awready
        @(posedge clock);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        repeat (delay) @(posedge clock);
        bready <= 1'b1;
        @(negedge clock);
        while (!bvalid) @(negedge clock);
        check_resp("bresp", resp[1:0], bresp);
        @(posedge clock);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, input logic [31:0] data,
                            input logic [31:0] resp);
        int delay;
        delay = 1 + int'($urandom % 3);
        @(posedge clock);
        araddr <= addr[3:0];
        arvalid <= 1'b1;
        @(negedge clock);
        while (!arready) @(negedge clock);
        @(posedge clock);
        arvalid <= 1'b0;
        repeat (delay) @(posedge clock);
        rready <= 1'b1;
        @(negedge clock);
        while (!rvalid) @(negedge clock);
        check_word("rdata", irq_word_u'(data), irq_word_u'(rdata));
        check_resp("rresp", resp[1:0], rresp);
        @(posedge clock);
        rready <= 1'b0;
    endtask

    task automatic pulse_source(input logic [31:0] bits);
        @(posedge clock);
        sources <= irq_sources_t'(bits[10:0]);
        @(posedge clock);
        sources <= '0;
    endtask

    task automatic wait_level(input logic level, input logic [31:0] limit);
        for (int k = 0; k < int'(limit); k++) begin
            @(negedge clock);
            if (nIRQ === level) return;
        end
        abort_run("nIRQ did not reach the expected level in time");
    endtask

    task automatic load_patterns();
        int fd;
        int n;
        string line;
        logic [7:0] op;
        logic [31:0] a, b, c;
        fd = $fopen("irq_patterns.txt", "r");
        if (fd == 0) abort_run("could not open irq_patterns.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h %h", op, a, b, c);
                if (n == 4) begin
                    op_q.push_back(op);
                    a_q.push_back(a);
                    b_q.push_back(b);
                    c_q.push_back(c);
                end
            end
        end
        $fclose(fd);
    endtask

    // watchdog sized from the pattern count plus two frames
    initial begin
        wait (loaded);
        #(watchdog_time);
        abort_run("run timed out before the patterns finished");
    end

    initial begin
        void'($urandom(91597));
        reset = 1'b1;
        awaddr = '0;
        araddr = '0;
        awvalid = 1'b0;
        wvalid = 1'b0;
        wdata = '0;
        bready = 1'b0;
        arvalid = 1'b0;
        rready = 1'b0;
        sources = '0;
        cpu_mode = 5'h1f; // system mode
        loaded = 1'b0;
        load_patterns();
        watchdog_time = (longint'(op_q.size()) * 8 + 2 * h_total * v_total) * 4;
        loaded = 1'b1;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        for (int i = 0; i < op_q.size(); i++) begin
            case (op_q[i])
                "W": axi_write(a_q[i], b_q[i], c_q[i]);
                "R": axi_read(a_q[i], b_q[i], c_q[i]);
                "P": pulse_source(a_q[i]);
                "M": begin
                    @(posedge clock);
                    cpu_mode <= a_q[i][4:0];
                end
                "C": repeat (a_q[i]) @(posedge clock);
                "L": begin
                    @(negedge clock);
                    check_level("nIRQ", a_q[i][0], nIRQ);
                end
                "N": wait_level(a_q[i][0], b_q[i]);
                default: abort_run("unknown operation in the pattern file");
            endcase
        end
        $display("all tests passed");
        $finish;
    end

endmodule

// File: irq_patterns.txt
# op a b c, values in hex. W addr data resp, R addr data resp, P source bits,
# M cpu_mode, C cycles, L nIRQ level, N nIRQ level and cycle limit
L 1 0 0
R 0 0 0
R 4 0 0
R 8 0 0
R 1 0 2
W c 0 2
W 3 ffffffff 2
R 0 0 0
P 001 0 0
C 2 0 0
R 0 0 0
W 0 00000008 0
R 0 00080008 0
P 220 0 0
W 0 00001108 0
R 0 11081108 0
W 0 01001108 0
R 0 10081108 0
W 0 00001108 0
R 0 10081108 0
L 1 0 0
W 0 10081108 0
R 0 00001108 0
W 4 1 0
R 4 1 0
C 2 0 0
L 1 0 0
P 001 0 0
L 1 0 0
C 1 0 0
L 0 0 0
M 12 0 0
N 1 10 0
M 1f 0 0
N 0 10 0
W 4 0 0
N 1 10 0
W 4 1 0
N 0 10 0
W 0 00080008 0
L 1 0 0
W 8 2000 0
R 8 2000 0
W 0 00040004 0
N 0 12000 0
R c 20 0
R 0 00040004 0
W 0 00040004 0
N 1 8 0
W 0 00030002 0
N 0 200 0
R 0 00020002 0
W 0 00030001 0
N 1 8 0
N 0 12000 0
R 0 00010001 0
R c a0 0
W 4 0 0
N 1 8 0

// File: filelist.f
gba_irq_pkg.sv
video_timing.sv
interrupt_controller.sv
irq_regs.sv
gba_irq_top.sv
tb_clock.sv
gba_irq_chk.sv
gba_irq_tb.sv

// File: run.sh
#!/bin/sh
set -e
verilator --binary --timing --assert --top-module gba_irq_tb -f filelist.f
./obj_dir/Vgba_irq_tb 2>&1 | tee /dev/stderr | grep -q "all tests passed"
